// ==== source/mul_pkg.sv ====
package mul_pkg;

	// Operand and product widths.
	localparam int xlen = 64;              // Width of one RV64 operand.
	localparam int ext_w = xlen + 2;       // Two extra sign bits carry unsigned operands through Booth.
	localparam int prod_w = 2 * ext_w;     // Width of a partial-product row and of the raw product.
	localparam int booth_rows = ext_w / 2; // One radix-4 digit per pair of multiplicand bits.

	// Signedness of the operand pair.
	// Bit 0 flags a signed multiplicand and bit 1 a signed multiplier.
	typedef enum logic [1:0] {
		mul_uu = 2'b00, // MULHU and unsigned word forms.
		mul_su = 2'b01, // Only the multiplicand is signed.
		mul_us = 2'b10, // Only the multiplier is signed.
		mul_ss = 2'b11  // MUL, MULH and MULW.
	} mul_kind_e;

	// One request as offered by the execute stage.
	typedef struct packed {
		logic word;                    // Multiply the low 32 bits of each operand.
		mul_kind_e kind;               // Signedness of the two operands.
		logic [xlen-1:0] multiplicand; // Sliced into the Booth windows.
		logic [xlen-1:0] multiplier;   // Selected and shifted by each Booth row.
	} mul_req_t;

	// The full 128-bit product, split for the two result registers.
	typedef struct packed {
		logic [xlen-1:0] hi;
		logic [xlen-1:0] lo;
	} mul_resp_t;

	// One Booth row as it enters the reduction tree.
	typedef struct packed {
		logic [prod_w-1:0] pp; // Selected multiple, shifted into place and inverted when negative.
		logic neg;             // The +1 that finishes the two's-complement negation.
	} booth_row_t;

endpackage

// ==== source/mul_issue.sv ====
module mul_issue
	import mul_pkg::*;
(
	input mul_req_t req,
	input logic mul_valid,
	output logic [ext_w-1:0] b_ext,
	output logic [2:0] windows [booth_rows]
);

	logic a_signed;
	logic b_signed;
	logic [ext_w-1:0] a_ext;
	logic [ext_w:0] a_pad;

	// Builds the 66-bit form of one operand.
	// Word requests keep the low half and refill the upper half from bit 31.
	function automatic logic [ext_w-1:0] extend_op(
		input logic [xlen-1:0] op,
		input logic word,
		input logic is_signed
	);
		logic sign;
		logic [xlen-1:0] body;
		sign = is_signed & (word ? op[xlen/2-1] : op[xlen-1]);
		body = word ? {{(xlen/2){sign}}, op[xlen/2-1:0]} : op;
		return {{(ext_w-xlen){sign}}, body};
	endfunction

	assign a_signed = (req.kind == mul_su) || (req.kind == mul_ss);
	assign b_signed = (req.kind == mul_us) || (req.kind == mul_ss);

	// Both operands read as zero while no request is offered.
	assign a_ext = mul_valid ? extend_op(req.multiplicand, req.word, a_signed) : '0;
	assign b_ext = mul_valid ? extend_op(req.multiplier, req.word, b_signed) : '0;

	assign a_pad = {a_ext, 1'b0}; // The zero below bit 0 opens the first window.

	// Window i covers multiplicand bits 2i+1 down to 2i-1, so neighbours share one bit.
	always_comb begin
		for (int i = 0; i < booth_rows; i++) begin
			windows[i] = a_pad[2*i +: 3];
		end
	end

endmodule

// ==== source/booth_pp.sv ====
module booth_pp
	import mul_pkg::*;
#(
	parameter int row_idx = 0
) (
	input logic [2:0] window,
	input logic [ext_w-1:0] b_ext,
	output booth_row_t row
);

	logic [ext_w:0] one_b;
	logic [ext_w:0] two_b;
	logic [ext_w:0] mult;
	logic [ext_w:0] picked;
	logic [prod_w-1:0] wide;
	logic neg;

	assign one_b = {b_ext[ext_w-1], b_ext}; // One extra bit keeps room for 2B.
	assign two_b = {b_ext, 1'b0};

	// Radix-4 digit decode.
	always_comb begin
		mult = '0;
		neg = 1'b0;
		case (window)
			3'b001, 3'b010: mult = one_b;
			3'b011: mult = two_b;
			3'b100: begin
				mult = two_b;
				neg = 1'b1;
			end
			3'b101, 3'b110: begin
				mult = one_b;
				neg = 1'b1;
			end
			default: mult = '0; // Windows 000 and 111 give a zero digit.
		endcase
	end

	assign picked = neg ? ~mult : mult; // The missing +1 travels in row.neg.
	assign wide = {{(prod_w-ext_w-1){picked[ext_w]}}, picked};

	// Low bits shifted in stay zero, so the +1 lands exactly at bit 2*row_idx.
	assign row.pp = wide << (2 * row_idx);
	assign row.neg = neg;

endmodule

// ==== source/pp_compress.sv ====
module pp_compress
	import mul_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic mul_valid,
	input booth_row_t rows [booth_rows],
	output logic mul_ready,
	output logic out_valid,
	output mul_resp_t resp
);

	logic accept;
	logic s1_valid;
	logic s2_valid;
	booth_row_t s1_rows [booth_rows];
	logic [prod_w-1:0] corr_row;
	logic [prod_w-1:0] tree_sum;
	logic [prod_w-1:0] tree_carry;
	logic [prod_w-1:0] s2_sum;
	logic [prod_w-1:0] s2_carry;
	logic [prod_w-1:0] product;

	// Number of rows left after lvl levels of 3:2 compression.
	function automatic int rows_at(input int lvl);
		int n;
		n = booth_rows + 1;
		for (int k = 0; k < lvl; k++) begin
			n = (n / 3) * 2 + n % 3;
		end
		return n;
	endfunction

	// Levels needed to bring the tree down to a sum and a carry vector.
	function automatic int csa_levels();
		int lvl;
		lvl = 0;
		while (rows_at(lvl) > 2) begin
			lvl = lvl + 1;
		end
		return lvl;
	endfunction

	assign accept = mul_valid & mul_ready;

	// Pipeline occupancy. Only one operation is held at a time.
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= accept;
			s2_valid <= s1_valid; // No back-pressure, so stage one always moves on.
		end
	end

	// Stage one captures the Booth rows.
	always_ff @(posedge clk) begin
		if (accept) begin
			s1_rows <= rows;
		end
	end

	// All negate bits go into one extra row, each at its own row offset.
	always_comb begin
		corr_row = '0;
		for (int i = 0; i < booth_rows; i++) begin
			corr_row[2*i] = s1_rows[i].neg;
		end
	end

	// Carry-save tree. Level l holds rows_at(l) vectors of full product width.
	for (genvar l = 0; l <= csa_levels(); l++) begin : g_lvl
		logic [prod_w-1:0] v [rows_at(l)];

		if (l == 0) begin : g_leaf
			for (genvar i = 0; i < booth_rows; i++) begin : g_in
				assign v[i] = s1_rows[i].pp;
			end
			assign v[booth_rows] = corr_row;
		end else begin : g_node
			for (genvar g = 0; g < rows_at(l-1) / 3; g++) begin : g_csa
				logic [prod_w-1:0] x;
				logic [prod_w-1:0] y;
				logic [prod_w-1:0] z;
				logic [prod_w-1:0] maj;

				assign x = g_lvl[l-1].v[3*g];
				assign y = g_lvl[l-1].v[3*g+1];
				assign z = g_lvl[l-1].v[3*g+2];
				assign maj = (x & y) | (x & z) | (y & z);
				assign v[2*g] = x ^ y ^ z;
				assign v[2*g+1] = {maj[prod_w-2:0], 1'b0}; // Carries move up one bit.
			end
			// Rows that do not fill a group of three pass straight down.
			for (genvar r = 0; r < rows_at(l-1) % 3; r++) begin : g_pass
				assign v[2*(rows_at(l-1)/3)+r] = g_lvl[l-1].v[3*(rows_at(l-1)/3)+r];
			end
		end

		if (l == csa_levels()) begin : g_root
			assign tree_sum = v[0];
			assign tree_carry = v[1];
		end
	end

	// Stage two holds the redundant form of the product.
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_sum <= tree_sum;
			s2_carry <= tree_carry;
		end
	end

	assign product = s2_sum + s2_carry; // The carry out of bit 131 is meaningless here.

	assign resp.hi = product[2*xlen-1:xlen];
	assign resp.lo = product[xlen-1:0];

	assign mul_ready = ~(s1_valid | s2_valid);
	assign out_valid = s2_valid;

endmodule

// ==== source/mul_unit.sv ====
module mul_unit
	import mul_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic mul_valid,
	input mul_req_t req,
	input logic flush,
	output logic mul_ready,
	output logic out_valid,
	output mul_resp_t resp
);

	logic [ext_w-1:0] b_ext;
	logic [2:0] windows [booth_rows];
	booth_row_t rows [booth_rows];

	// Operand extension and window slicing.
	mul_issue u_issue (
		.req(req),
		.mul_valid(mul_valid),
		.b_ext(b_ext),
		.windows(windows)
	);

	// One partial-product row per Booth digit.
	for (genvar i = 0; i < booth_rows; i++) begin : g_row
		booth_pp #(
			.row_idx(i)
		) u_row (
			.window(windows[i]),
			.b_ext(b_ext),
			.row(rows[i])
		);
	end

	// Both pipeline registers, the tree and the final adder.
	pp_compress u_compress (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.mul_valid(mul_valid),
		.rows(rows),
		.mul_ready(mul_ready),
		.out_valid(out_valid),
		.resp(resp)
	);

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

	// Reset is held for eight rising edges and released on a falling edge.
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== testbench/mul_checker.sv ====
module mul_checker
	import mul_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic mul_valid,
	input mul_req_t req,
	input logic flush,
	input logic mul_ready,
	input logic out_valid,
	input mul_resp_t resp
);

	timeunit 1ns;
	timeprecision 1ps;

	logic accept;
	logic after_1;         // An accept one edge ago survived without a flush.
	logic after_2;         // The same operation is now two edges old.
	logic idle;            // No operation may be in flight.
	logic [127:0] pend_exp;

	// An operand as a 128-bit two's-complement value.
	function automatic logic [127:0] widen(
		input logic [63:0] op,
		input logic word,
		input logic sgn
	);
		logic [127:0] v;
		if (word) begin
			v = {{96{sgn & op[31]}}, op[31:0]};
		end else begin
			v = {{64{sgn & op[63]}}, op};
		end
		return v;
	endfunction

	// The low 128 bits of the product do not depend on how far the operands are extended.
	function automatic logic [127:0] expected_product(input mul_req_t r);
		logic [127:0] a;
		logic [127:0] b;
		a = widen(r.multiplicand, r.word, r.kind[0]);
		b = widen(r.multiplier, r.word, r.kind[1]);
		return a * b;
	endfunction

	assign accept = mul_valid && mul_ready;

	always @(posedge clk) begin
		if (accept) begin
			pend_exp <= expected_product(req);
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			after_1 <= 1'b0;
			after_2 <= 1'b0;
			idle <= 1'b1;
		end else begin
			after_1 <= accept && !flush;
			after_2 <= after_1 && !flush;
			if (flush || out_valid) begin
				idle <= 1'b1; // A flushed or finished operation leaves nothing behind.
			end else if (accept) begin
				idle <= 1'b0;
			end
		end
	end

	a_product: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> resp == pend_exp)
	else begin
		tb_top.note_mismatch("resp", $sampled(pend_exp), $sampled(resp));
		$error("product does not match the accepted request");
	end

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		after_2 |-> out_valid)
	else begin
		tb_top.note_mismatch("out_valid", 128'd1, 128'($sampled(out_valid)));
		$error("out_valid missing two edges after an accept");
	end

	a_single: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
	else begin
		tb_top.note_mismatch("out_valid", 128'd0, 128'($sampled(out_valid)));
		$error("out_valid longer than one cycle");
	end

	// Covers the early cycles of an operation and the time after a flush.
	a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		after_1 || idle |-> !out_valid)
	else begin
		tb_top.note_mismatch("out_valid", 128'd0, 128'($sampled(out_valid)));
		$error("out_valid without a live operation");
	end

	a_busy: assert property (@(posedge clk) disable iff (!rst_n)
		after_1 || after_2 |-> !mul_ready)
	else begin
		tb_top.note_mismatch("mul_ready", 128'd0, 128'($sampled(mul_ready)));
		$error("mul_ready high while an operation is in flight");
	end

	a_free: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> mul_ready)
	else begin
		tb_top.note_mismatch("mul_ready", 128'd1, 128'($sampled(mul_ready)));
		$error("mul_ready low after the result");
	end

	a_flush: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> {out_valid, mul_ready} == 2'b01)
	else begin
		tb_top.note_mismatch("{out_valid,mul_ready}", 128'd1,
			128'({$sampled(out_valid), $sampled(mul_ready)}));
		$error("pipeline not empty after flush");
	end

	a_reset: assert property (@(posedge clk)
		!rst_n |=> {out_valid, mul_ready} == 2'b01)
	else begin
		tb_top.note_mismatch("{out_valid,mul_ready}", 128'd1,
			128'({$sampled(out_valid), $sampled(mul_ready)}));
		$error("pipeline not empty after reset");
	end

endmodule

// ==== testbench/tb_top.sv ====
module tb_top
	import mul_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_directed = 4 * 2 * 5 * 2;
	localparam int n_random = 200;
	localparam int n_ops = n_directed + n_random;
	localparam int cycle_limit = 2 * n_ops * 4 + 200;

	logic clk;
	logic rst_n;
	logic mul_valid;
	mul_req_t req;
	logic flush;
	logic mul_ready;
	logic out_valid;
	mul_resp_t resp;

	int mismatch_count = 0;
	int other_errors = 0;
	int cycles;
	logic [31:0] lcg_state = 32'h2218;

	tb_clock_gen u_clock (
		.clk(clk),
		.rst_n(rst_n)
	);

	mul_unit u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.mul_valid(mul_valid),
		.req(req),
		.flush(flush),
		.mul_ready(mul_ready),
		.out_valid(out_valid),
		.resp(resp)
	);

	bind mul_unit mul_checker u_checker (
		.clk(clk),
		.rst_n(rst_n),
		.mul_valid(mul_valid),
		.req(req),
		.flush(flush),
		.mul_ready(mul_ready),
		.out_valid(out_valid),
		.resp(resp)
	);

	// Called from the action blocks of the bound assertions.
	task automatic note_mismatch(
		input string name,
		input logic [127:0] expected,
		input logic [127:0] actual
	);
		mismatch_count++;
		$display("FAIL %0d ns %s expected %0h actual %0h", $time, name, expected, actual);
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_random(output logic [31:0] v);
		lcg_state = lcg_step(lcg_state);
		v = lcg_state;
	endtask

	function automatic logic [63:0] corner(input int i);
		case (i)
			0: return 64'h0;
			1: return 64'h1;
			2: return 64'hffff_ffff_ffff_ffff;
			3: return 64'h8000_0000_0000_0000;
			default: return 64'h5a5a_5a5a_8000_0000; // Most negative word under junk bits.
		endcase
	endfunction

	// Called on a falling edge and returns on one.
	task automatic issue_op(input mul_req_t r, input int flush_after);
		while (!mul_ready) @(negedge clk);
		mul_valid = 1'b1;
		req = r;
		@(negedge clk);
		mul_valid = 1'b0; // Ready was high, so the rising edge just passed accepted it.
		if (flush_after > 0) begin
			repeat (flush_after - 1) @(negedge clk);
			flush = 1'b1;
			@(negedge clk);
			flush = 1'b0;
		end
	endtask

	initial begin
		mul_req_t r;
		logic [31:0] hi;
		logic [31:0] lo;
		logic [31:0] ctl;
		int flush_after;
		mul_valid = 1'b0;
		flush = 1'b0;
		req = '0;
		wait (rst_n === 1'b1);
		@(negedge clk);
		for (int k = 0; k < 4; k++) begin
			for (int w = 0; w < 2; w++) begin
				for (int i = 0; i < 5; i++) begin
					for (int j = 0; j < 2; j++) begin
						r.word = w[0];
						r.kind = mul_kind_e'(k[1:0]);
						r.multiplicand = corner(i);
						r.multiplier = (j == 0) ? corner(i) : corner(4 - i);
						issue_op(r, 0);
					end
				end
			end
		end
		for (int n = 0; n < n_random; n++) begin
			next_random(hi);
			next_random(lo);
			r.multiplicand = {hi, lo};
			next_random(hi);
			next_random(lo);
			r.multiplier = {hi, lo};
			next_random(ctl);
			r.kind = mul_kind_e'(ctl[31:30]); // Upper LCG bits are the least regular.
			r.word = ctl[29];
			flush_after = (n % 29 == 5) ? 1 : ((n % 29 == 17) ? 2 : 0);
			repeat (ctl[28:27]) @(negedge clk);
			issue_op(r, flush_after);
		end
		while (!mul_ready) @(negedge clk);
		repeat (4) @(negedge clk);
		finish_run();
	end

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish");
		other_errors++;
		finish_run();
	end

endmodule

// ==== filelist.f ====
source/mul_pkg.sv
source/mul_issue.sv
source/booth_pp.sv
source/pp_compress.sv
source/mul_unit.sv
testbench/tb_clock_gen.sv
testbench/mul_checker.sv
testbench/tb_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f filelist.f
	./obj_dir/Vtb_top +verilator+error+limit+1000 | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
